//--- common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath word width in bits
`define CPU_WORD_W 32

// general purpose registers r0..r15
`define CPU_NUM_REGS 16

// execute runs through T0..T4
`define CPU_LAST_STEP 4

`endif

//--- common/cpuPkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpuPkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regIdx_t;

    // register forms first, ror sits at 8 as in the existing encoding
    typedef enum logic [4:0] {
        opAdd  = 5'd0,
        opSub  = 5'd1,
        opAnd  = 5'd2,
        opOr   = 5'd3,
        opShl  = 5'd4,
        opShr  = 5'd5,
        opShra = 5'd6,
        opRol  = 5'd7,
        opRor  = 5'd8,
        opNeg  = 5'd9,
        opNot  = 5'd10,
        opAddi = 5'd11,  // immediate forms
        opAndi = 5'd12,
        opOri  = 5'd13
    } opcode_t;

    typedef struct packed {
        opcode_t     op;
        regIdx_t     ra;     // destination
        regIdx_t     rb;     // first source, goes to Y
        regIdx_t     rc;     // second source, driven on the bus
        logic [14:0] spare;
    } rForm_t;

    typedef struct packed {
        opcode_t     op;
        regIdx_t     ra;
        regIdx_t     rb;
        logic [18:0] imm;    // sign-extended before use
    } iForm_t;

    typedef union packed {
        rForm_t rForm;
        iForm_t iForm;
    } instr_t;

    typedef enum logic [2:0] {
        srcNone,
        srcRegFile,
        srcPc,
        srcIr,
        srcY,
        srcZLo,
        srcMdr,
        srcImmediate
    } busSrc_t;

endpackage

`default_nettype wire

//--- common/busCtrlIf.sv
`default_nettype none

interface busCtrlIf;

    cpuPkg::busSrc_t busSrc;      // which block drives the bus
    cpuPkg::regIdx_t rfSel;
    logic            rfIn;
    logic            pcIn;
    logic            irIn;
    logic            yIn;
    logic            zIn;
    logic            marIn;
    logic            mdrIn;
    logic            mdrLoadExt;  // MDR source is loadData, else instrIn
    logic            incPc;       // with pcIn, PC counts instead of taking the bus
    cpuPkg::opcode_t aluOp;
    cpuPkg::instr_t  ir;          // IR contents back to the sequencer

    modport control (
        output busSrc, rfSel, rfIn, pcIn, irIn, yIn, zIn, marIn, mdrIn,
               mdrLoadExt, incPc, aluOp,
        input  ir
    );

    modport datapath (
        input  busSrc, rfSel, rfIn, pcIn, irIn, yIn, zIn, marIn, mdrIn,
               mdrLoadExt, incPc, aluOp,
        output ir
    );

    modport regs (
        input rfSel, rfIn
    );

endinterface

`default_nettype wire

//--- alu/alu.sv
`default_nettype none

`include "cpu_params.svh"

module alu (
    input  wire cpuPkg::word_t   a,
    input  wire cpuPkg::word_t   b,
    input  wire cpuPkg::opcode_t op,
    output cpuPkg::word_t        y
);

    logic [4:0]                amount;
    logic [2*`CPU_WORD_W-1:0] doubled;
    logic [2*`CPU_WORD_W-1:0] rolWide;
    logic [2*`CPU_WORD_W-1:0] rorWide;

    assign amount  = b[4:0];        // shift count from the low bits only
    assign doubled = {a, a};

    // rotate by shifting two copies side by side
    assign rolWide = doubled << amount;
    assign rorWide = doubled >> amount;

    always_comb begin
        case (op)
            cpuPkg::opAdd,
            cpuPkg::opAddi: y = a + b;
            cpuPkg::opSub:  y = a - b;
            cpuPkg::opAnd,
            cpuPkg::opAndi: y = a & b;
            cpuPkg::opOr,
            cpuPkg::opOri:  y = a | b;
            cpuPkg::opShl:  y = a << amount;
            cpuPkg::opShr:  y = a >> amount;
            cpuPkg::opShra: y = cpuPkg::word_t'($signed(a) >>> amount);  // sign fill
            cpuPkg::opRol:  y = rolWide[2*`CPU_WORD_W-1:`CPU_WORD_W];
            cpuPkg::opRor:  y = rorWide[`CPU_WORD_W-1:0];
            cpuPkg::opNeg:  y = -a;          // unary ops work on Y
            cpuPkg::opNot:  y = ~a;
            default:        y = '0;
        endcase
    end

    always_comb begin
        if (!$isunknown(op)) begin
            assert (op inside {cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                               cpuPkg::opShl, cpuPkg::opShr, cpuPkg::opShra, cpuPkg::opRol,
                               cpuPkg::opRor, cpuPkg::opNeg, cpuPkg::opNot, cpuPkg::opAddi,
                               cpuPkg::opAndi, cpuPkg::opOri})
                else $error("undefined ALU opcode %0d", op);
        end
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`default_nettype none

`include "cpu_params.svh"

module registerFile (
    input  wire logic          Clock,
    input  wire logic          rstN,
    busCtrlIf.regs             regs,
    input  wire cpuPkg::word_t bus,
    output cpuPkg::word_t      rfData
);

    cpuPkg::word_t regBank [`CPU_NUM_REGS];

    // every register comes out of reset as zero
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regBank[i] <= '0;
            end
        end else if (regs.rfIn) begin
            regBank[regs.rfSel] <= bus;
        end
    end

    assign rfData = regBank[regs.rfSel];   // read port shares the write address

endmodule

`default_nettype wire

//--- source/busDatapath.sv
`default_nettype none

`include "cpu_params.svh"

module busDatapath (
    input  wire logic          Clock,
    input  wire logic          rstN,
    input  wire cpuPkg::word_t loadData,
    input  wire cpuPkg::word_t instrIn,
    busCtrlIf.datapath         ctl,
    input  wire cpuPkg::word_t rfData,
    input  wire cpuPkg::word_t aluOut,
    output cpuPkg::word_t      bus,
    output cpuPkg::word_t      yOut,
    output cpuPkg::word_t      result,
    output cpuPkg::word_t      memAddr,
    output logic               zero
);

    cpuPkg::word_t  pcReg;
    cpuPkg::word_t  marReg;
    cpuPkg::word_t  mdrReg;
    cpuPkg::word_t  yReg;
    cpuPkg::word_t  zReg;
    cpuPkg::instr_t irReg;
    cpuPkg::word_t  immExt;

    assign immExt = {{(`CPU_WORD_W - 19){irReg.iForm.imm[18]}}, irReg.iForm.imm};

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg   <= '0;
            zReg   <= '0;
            irReg  <= '0;
        end else begin
            if (ctl.pcIn) pcReg <= ctl.incPc ? pcReg + cpuPkg::word_t'(1) : bus;
            if (ctl.marIn) marReg <= bus;
            if (ctl.mdrIn) mdrReg <= ctl.mdrLoadExt ? loadData : instrIn;
            if (ctl.irIn) irReg <= mdrReg;   // direct path, bus carries PC then
            if (ctl.yIn) yReg <= bus;
            if (ctl.zIn) zReg <= aluOut;
        end
    end

    always_comb begin
        case (ctl.busSrc)
            cpuPkg::srcRegFile:   bus = rfData;
            cpuPkg::srcPc:        bus = pcReg;
            cpuPkg::srcIr:        bus = irReg;
            cpuPkg::srcY:         bus = yReg;
            cpuPkg::srcZLo:       bus = zReg;
            cpuPkg::srcMdr:       bus = mdrReg;
            cpuPkg::srcImmediate: bus = immExt;
            default:              bus = '0;   // nothing driving
        endcase
    end

    assign ctl.ir  = irReg;
    assign yOut    = yReg;
    assign result  = zReg;
    assign zero    = (zReg == '0);
    assign memAddr = marReg;   // no memory behind MAR yet

    // any block that takes the bus needs a real driver on it
    busSrcLegal: assert property (@(posedge Clock) disable iff (!rstN)
        (ctl.rfIn || ctl.yIn || ctl.zIn || ctl.marIn || (ctl.pcIn && !ctl.incPc))
            |-> !$isunknown(ctl.busSrc) && (ctl.busSrc != cpuPkg::srcNone))
        else $error("bus read with no source selected, busSrc %0d", ctl.busSrc);

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`default_nettype none

`include "cpu_params.svh"

module controlUnit (
    input  wire logic            Clock,
    input  wire logic            rstN,
    input  wire logic            loadStrobe,
    input  wire cpuPkg::regIdx_t loadSel,
    input  wire logic            start,
    output logic                 busy,
    output logic                 done,
    busCtrlIf.control            ctl
);

    localparam int stepW = $clog2(`CPU_LAST_STEP + 1);

    typedef enum logic [1:0] {modeIdle, modeLoading, modeExecuting} mode_t;

    mode_t           mode;
    logic [stepW-1:0] step;
    cpuPkg::regIdx_t loadSelQ;   // target register held for the write cycle
    logic            isImm;
    logic            lastStep;

    assign lastStep = (step == stepW'(`CPU_LAST_STEP));
    assign isImm = ctl.ir.rForm.op inside {cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri};

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mode     <= modeIdle;
            step     <= '0;
            loadSelQ <= '0;
        end else begin
            case (mode)
                modeIdle: begin
                    if (loadStrobe) begin      // load wins if both strobes arrive
                        mode     <= modeLoading;
                        loadSelQ <= loadSel;
                    end else if (start) begin
                        mode <= modeExecuting;
                        step <= '0;
                    end
                end
                modeLoading: mode <= modeIdle;
                modeExecuting: begin
                    if (lastStep) begin
                        mode <= modeIdle;
                        step <= '0;
                    end else begin
                        step <= step + stepW'(1);
                    end
                end
                default: mode <= modeIdle;
            endcase
        end
    end

    always_comb begin
        ctl.busSrc     = cpuPkg::srcNone;
        ctl.rfSel      = '0;
        ctl.rfIn       = 1'b0;
        ctl.pcIn       = 1'b0;
        ctl.irIn       = 1'b0;
        ctl.yIn        = 1'b0;
        ctl.zIn        = 1'b0;
        ctl.marIn      = 1'b0;
        ctl.mdrIn      = 1'b0;
        ctl.mdrLoadExt = 1'b0;
        ctl.incPc      = 1'b0;
        ctl.aluOp      = ctl.ir.rForm.op;

        case (mode)
            modeIdle: begin
                // MDR catches the word on the strobe edge itself
                ctl.mdrIn      = loadStrobe | start;
                ctl.mdrLoadExt = loadStrobe;
            end
            modeLoading: begin
                ctl.busSrc = cpuPkg::srcMdr;
                ctl.rfSel  = loadSelQ;
                ctl.rfIn   = 1'b1;
            end
            modeExecuting: begin
                case (step)
                    stepW'(1): begin   // T1 IR <- MDR, MAR <- PC, PC + 1
                        ctl.busSrc = cpuPkg::srcPc;
                        ctl.marIn  = 1'b1;
                        ctl.pcIn   = 1'b1;
                        ctl.incPc  = 1'b1;
                        ctl.irIn   = 1'b1;
                    end
                    stepW'(2): begin   // T2 Y <- rb
                        ctl.busSrc = cpuPkg::srcRegFile;
                        ctl.rfSel  = ctl.ir.rForm.rb;
                        ctl.yIn    = 1'b1;
                    end
                    stepW'(3): begin   // T3 Z <- Y op (rc or imm)
                        ctl.busSrc = isImm ? cpuPkg::srcImmediate : cpuPkg::srcRegFile;
                        ctl.rfSel  = ctl.ir.rForm.rc;
                        ctl.zIn    = 1'b1;
                    end
                    stepW'(4): begin   // T4 ra <- Z
                        ctl.busSrc = cpuPkg::srcZLo;
                        ctl.rfSel  = ctl.ir.rForm.ra;
                        ctl.rfIn   = 1'b1;
                    end
                    default: ;         // T0 holds while MDR settles
                endcase
            end
            default: ;
        endcase
    end

    assign busy = (mode != modeIdle);
    assign done = (mode == modeExecuting) && lastStep;

    strobeWhileBusy: assert property (@(posedge Clock) disable iff (!rstN)
        busy |-> !(loadStrobe || start))
        else $error("strobe raised while busy");

    // done only closes a busy window that an accepted start opened
    doneInsideBusy: assert property (@(posedge Clock) disable iff (!rstN)
        done |-> busy && $past(start && !loadStrobe && !busy, 5))
        else $error("done without a start opening its busy window");

    // done rises four edges after the start edge, seen at the fifth sample
    startToDone: assert property (@(posedge Clock) disable iff (!rstN)
        (start && !loadStrobe && !busy) |-> ##5 done)
        else $error("done not four cycles after start");

endmodule

`default_nettype wire

//--- source/cpuCore.sv
`default_nettype none

module cpuCore (
    input  wire logic            Clock,
    input  wire logic            rstN,
    input  wire logic            loadStrobe,
    input  wire cpuPkg::regIdx_t loadSel,
    input  wire cpuPkg::word_t   loadData,
    input  wire logic            start,
    input  wire cpuPkg::word_t   instrIn,
    output logic                 busy,
    output logic                 done,
    output cpuPkg::word_t        result,
    output logic                 zero,
    output cpuPkg::word_t        memAddr
);

    cpuPkg::word_t bus;
    cpuPkg::word_t rfData;
    cpuPkg::word_t aluOut;
    cpuPkg::word_t yOut;

    busCtrlIf ctl ();

    controlUnit controlUnit_i (
        .Clock      (Clock),
        .rstN       (rstN),
        .loadStrobe (loadStrobe),
        .loadSel    (loadSel),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .ctl        (ctl.control)
    );

    busDatapath busDatapath_i (
        .Clock    (Clock),
        .rstN     (rstN),
        .loadData (loadData),
        .instrIn  (instrIn),
        .ctl      (ctl.datapath),
        .rfData   (rfData),
        .aluOut   (aluOut),
        .bus      (bus),
        .yOut     (yOut),
        .result   (result),
        .memAddr  (memAddr),
        .zero     (zero)
    );

    registerFile registerFile_i (
        .Clock  (Clock),
        .rstN   (rstN),
        .regs   (ctl.regs),
        .bus    (bus),
        .rfData (rfData)
    );

    // A side is Y, B side is whatever sits on the bus
    alu alu_i (
        .a  (yOut),
        .b  (bus),
        .op (ctl.aluOp),
        .y  (aluOut)
    );

endmodule

`default_nettype wire

//--- test/cpuCoreTb.sv
`default_nettype none

module cpuCoreTb;

    localparam int maxRecords  = 32;
    localparam int doneLatency = 4;   // rising edges from the start edge to done

    logic            Clock;
    logic            rstN;
    logic            loadStrobe;
    cpuPkg::regIdx_t loadSel;
    cpuPkg::word_t   loadData;
    logic            start;
    cpuPkg::word_t   instrIn;
    logic            busy;
    logic            done;
    cpuPkg::word_t   result;
    logic            zero;
    cpuPkg::word_t   memAddr;

    cpuPkg::word_t vecMem [0:4*maxRecords-1];   // kind, field, data, expected
    int            nRecords;
    int            cycleLimit = 0;
    int            cycleCount = 0;
    int            execCount = 0;
    logic [31:0]   rngState = 32'd69;

    cpuCore dut_i (
        .Clock      (Clock),
        .rstN       (rstN),
        .loadStrobe (loadStrobe),
        .loadSel    (loadSel),
        .loadData   (loadData),
        .start      (start),
        .instrIn    (instrIn),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .zero       (zero),
        .memAddr    (memAddr)
    );

    initial Clock = 1'b0;
    always #20 Clock = ~Clock;

    // watchdog, armed once the vector count is known
    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $fatal(1, "stopped by watchdog");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic checkWord(input string name, input cpuPkg::word_t got,
                             input cpuPkg::word_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic runLoad(input cpuPkg::regIdx_t sel, input cpuPkg::word_t data);
        @(posedge Clock);
        loadStrobe <= 1'b1;
        loadSel    <= sel;
        loadData   <= data;
        @(posedge Clock);               // MDR takes loadData here
        loadStrobe <= 1'b0;
        @(negedge Clock);
        checkFlag("busy", busy, 1'b1);
        checkFlag("done", done, 1'b0);
        @(posedge Clock);               // register written from the bus
        @(negedge Clock);
        checkFlag("busy", busy, 1'b0);
    endtask

    task automatic runExecute(input cpuPkg::word_t instr, input cpuPkg::word_t expected);
        int   latency;
        logic sawDone;
        @(posedge Clock);
        start   <= 1'b1;
        instrIn <= instr;
        @(posedge Clock);               // start edge
        start <= 1'b0;
        @(negedge Clock);
        checkFlag("busy", busy, 1'b1);
        checkFlag("done", done, 1'b0);
        latency = 0;
        sawDone = 1'b0;
        while (!sawDone) begin
            @(posedge Clock);
            latency = latency + 1;
            @(negedge Clock);
            checkFlag("busy", busy, 1'b1);   // busy must cover done
            sawDone = done;
        end
        if (latency != doneLatency) begin
            abortRun($sformatf("done came %0d cycles after start instead of %0d",
                               latency, doneLatency));
        end
        checkWord("result", result, expected);
        checkFlag("zero", zero, expected == '0);
        checkWord("memAddr", memAddr, cpuPkg::word_t'(execCount));  // MAR holds the old PC
        execCount = execCount + 1;
        @(posedge Clock);
        @(negedge Clock);
        checkFlag("busy", busy, 1'b0);
        checkFlag("done", done, 1'b0);   // a single pulse only
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge Clock);
            @(negedge Clock);
            checkFlag("done", done, 1'b0);
        end
    endtask

    initial begin
        cpuPkg::word_t kind;
        cpuPkg::word_t field;
        rstN       <= 1'b0;
        loadStrobe <= 1'b0;
        loadSel    <= '0;
        loadData   <= '0;
        start      <= 1'b0;
        instrIn    <= '0;

        $readmemh("test/cpu_vectors.txt", vecMem);
        nRecords = 0;
        while (nRecords < maxRecords && vecMem[4*nRecords] != 32'hFFFF_FFFF) begin
            nRecords = nRecords + 1;
        end
        if (nRecords == 0 || nRecords == maxRecords) begin
            abortRun("vector file has no records or no end marker");
        end
        cycleLimit = 8 * nRecords + 50;

        repeat (5) @(posedge Clock);
        rstN <= 1'b1;
        @(negedge Clock);
        checkFlag("busy", busy, 1'b0);
        checkFlag("done", done, 1'b0);

        for (int i = 0; i < nRecords; i++) begin
            kind  = vecMem[4*i];
            field = vecMem[4*i+1];
            case (kind)
                32'd0: runLoad(cpuPkg::regIdx_t'(field[3:0]), vecMem[4*i+2]);
                32'd1: runExecute(field, vecMem[4*i+3]);
                default: abortRun($sformatf("record %0d has unknown kind %h", i, kind));
            endcase
            rngState = xorshift32(rngState);
            idleCycles(int'(rngState[1:0]));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/cpu_vectors.txt
// kind field data expected, one record per line
// kind 0 loads register <field> with <data>, kind 1 runs instruction <field>, FFFFFFFF ends
00000000 00000001 00001234 00000000
00000000 00000002 8000000F 00000000
00000000 00000003 00000004 00000000
00000000 00000004 F0000010 00000000
00000000 00000005 00001234 00000000
00000001 03098000 00000000 00001238 // add r6 r1 r3
00000001 43918000 00000000 F8000000 // ror r7 r2 r3
00000001 3C118000 00000000 000000F8 // rol r8 r2 r3
00000001 24898000 00000000 00012340 // shl r9 r1 r3
00000001 2D218000 00000000 0F000001 // shr r10 r4 r3
00000001 35A18000 00000000 FF000001 // shra r11 r4 r3
00000001 5E0FFFFE 00000000 00001232 // addi r12 r1 -2
00000001 66A000FF 00000000 00000010 // andi r13 r4 0xff
00000001 6F080F00 00000000 00001F34 // ori r14 r1 0xf00
00000001 07B30000 00000000 00002470 // add r15 r6 r6
00000001 00788000 00000000 000036A4 // add r0 r15 r1
00000001 0B0A8000 00000000 00000000 // sub r6 r1 r5
00000001 4B980000 00000000 FFFFFFFC // neg r7 r3
00000001 54080000 00000000 FFFFEDCB // not r8 r1
00000001 14A08000 00000000 00000010 // and r9 r4 r1
00000001 1D090000 00000000 8000123F // or r10 r1 r2
FFFFFFFF 00000000 00000000 00000000

//--- cpuCore.f
+incdir+common
common/cpuPkg.sv
common/busCtrlIf.sv
alu/alu.sv
source/registerFile.sv
source/busDatapath.sv
source/controlUnit.sv
source/cpuCore.sv
test/cpuCoreTb.sv

//--- Makefile
LOG := sim.log

sim:
	verilator --binary --timing -f cpuCore.f --top-module cpuCoreTb -o cpuCoreSim
	./obj_dir/cpuCoreSim 2>&1 | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
